/* hw/f27_pkg.sv */
// f27 affine scaler definitions
package f27_pkg;

	// float word layout, sign then exponent then stored fraction
	localparam int F27_W = 27;
	localparam int EXP_BIAS = 127;
	localparam int FRAC_W = 18;

	// integer results are clipped to this magnitude
	localparam int INT_MAX = 32767;

	// buffer sizes, the input depth is also the sender's starting credit
	localparam int IN_DEPTH = 4;
	localparam int OUT_DEPTH = 8;

	// coefficients after reset give y = x
	localparam logic [F27_W-1:0] GAIN_RESET = {1'b0, 8'd127, 18'd0};
	localparam logic [F27_W-1:0] OFFSET_RESET = '0;

	// coefficient load, sel picks gain (0) or offset (1)
	typedef struct packed {
		logic kind;
		logic sel;
		logic [2:0] pad;
		logic [F27_W-1:0] coef;
	} coef_view_t;

	// sample word, kind is 0
	typedef struct packed {
		logic kind;
		logic [14:0] pad;
		logic signed [15:0] sample;
	} sample_view_t;

	// one 32-bit input word, decoded by its top bit
	typedef union packed {
		coef_view_t coef_view;
		sample_view_t sample_view;
	} in_word_t;

endpackage

/* hw/f27_ops.sv */
// f27 combinational float blocks
`timescale 1ns/10ps

module f27_int2float (
	input logic signed [15:0] a,
	output logic [f27_pkg::F27_W-1:0] q
);
	logic [15:0] mag;
	logic [4:0] lead;
	logic [4:0] shamt;
	logic [33:0] shifted;
	logic [7:0] exp_q;

	// magnitude, -32768 folds to 0x8000 which is still correct unsigned
	assign mag = a[15] ? -a : a;

	// position of the highest set bit
	always_comb begin
		lead = '0;
		for (int i = 0; i < 16; i++) begin
			if (mag[i]) lead = 5'(i);
		end
	end

	// move the leading one up to bit 18, it is dropped as the hidden bit
	assign shamt = 5'(f27_pkg::FRAC_W) - lead;
	assign shifted = {18'b0, mag} << shamt;
	assign exp_q = 8'(f27_pkg::EXP_BIAS) + 8'(lead);

	// zero has no leading one, so it gets the all-zero word
	assign q = (a == 0) ? '0 : {a[15], exp_q, shifted[f27_pkg::FRAC_W-1:0]};
endmodule

module f27_float2int (
	input logic [f27_pkg::F27_W-1:0] a,
	output logic signed [15:0] q
);
	logic sgn;
	logic [7:0] ex;
	logic [17:0] fr;
	logic [33:0] shifted;
	logic [15:0] mag;

	assign sgn = a[26];
	assign ex = a[25:18];
	assign fr = a[17:0];

	// 1.fr with the binary point above bit 18, shifted by the unbiased exponent
	assign shifted = {15'b0, 1'b1, fr} << (ex - 8'(f27_pkg::EXP_BIAS));
	// integer part, fraction bits are truncated
	assign mag = shifted[33:18];

	always_comb begin
		if (ex < 8'(f27_pkg::EXP_BIAS)) begin
			// magnitude below one
			q = '0;
		end else if (ex > 8'(f27_pkg::EXP_BIAS + 14)) begin
			// too large for 16 bits
			q = sgn ? -16'(f27_pkg::INT_MAX) : 16'(f27_pkg::INT_MAX);
		end else begin
			q = sgn ? -mag : mag;
		end
	end
endmodule

module f27_mul (
	input logic [f27_pkg::F27_W-1:0] a,
	input logic [f27_pkg::F27_W-1:0] b,
	output logic [f27_pkg::F27_W-1:0] q
);
	logic [7:0] a_e, b_e;
	logic [17:0] a_m, b_m;
	logic [35:0] prod;
	logic [8:0] pre_exp;
	logic [7:0] prod_e;
	logic [17:0] prod_f;
	logic underflow;

	assign a_e = a[25:18];
	assign b_e = b[25:18];
	// mantissas with the hidden one, lowest fraction bit truncated
	assign a_m = {1'b1, a[17:1]};
	assign b_m = {1'b1, b[17:1]};

	assign prod = a_m * b_m;
	assign pre_exp = {1'b0, a_e} + {1'b0, b_e};

	// product lies in [1,4), so at most one bit of normalisation
	assign prod_e = prod[35] ? 8'(pre_exp - 9'd126) : 8'(pre_exp - 9'(f27_pkg::EXP_BIAS));
	assign prod_f = prod[35] ? prod[34:17] : prod[33:16];

	// flush to zero when the biased exponent would drop to zero or below
	assign underflow = pre_exp <= 9'(f27_pkg::EXP_BIAS);

	assign q = (underflow || a_e == 8'd0 || b_e == 8'd0) ? '0 :
		{a[26] ^ b[26], prod_e, prod_f};
endmodule

module f27_add (
	input logic [f27_pkg::F27_W-1:0] a,
	input logic [f27_pkg::F27_W-1:0] b,
	output logic [f27_pkg::F27_W-1:0] q
);
	logic a_s, b_s;
	logic [7:0] a_e, b_e;
	logic [17:0] a_m, b_m;
	logic a_larger;
	logic [7:0] diff_a, diff_b, big_e;
	logic [36:0] a_al, b_al, sum;
	logic [5:0] shamt;
	logic [53:0] norm;
	logic [7:0] sum_e;
	logic underflow;

	assign a_s = a[26];
	assign b_s = b[26];
	assign a_e = a[25:18];
	assign b_e = b[25:18];
	assign a_m = {1'b1, a[17:1]};
	assign b_m = {1'b1, b[17:1]};

	// larger magnitude decides the result sign and stays unshifted
	assign a_larger = (a_e > b_e) || ((a_e == b_e) && (a_m > b_m));
	assign diff_a = b_e - a_e;
	assign diff_b = a_e - b_e;
	assign big_e = (b_e > a_e) ? b_e : a_e;

	// align the smaller operand, a guard bit on top catches the carry
	assign a_al = a_larger ? {1'b0, a_m, 18'b0} :
		(diff_a > 8'd35) ? '0 : ({1'b0, a_m, 18'b0} >> diff_a);
	assign b_al = !a_larger ? {1'b0, b_m, 18'b0} :
		(diff_b > 8'd35) ? '0 : ({1'b0, b_m, 18'b0} >> diff_b);

	// unlike signs subtract the smaller from the larger
	assign sum = (a_s ^ b_s) ? (a_larger ? a_al - b_al : b_al - a_al) : a_al + b_al;

	// distance of the leading one from bit 36, 37 for a zero sum
	always_comb begin
		shamt = 6'd37;
		for (int i = 0; i < 37; i++) begin
			if (sum[i]) shamt = 6'(36 - i);
		end
	end

	// one extra shift drops the hidden bit
	assign norm = {sum, 17'b0} << (shamt + 6'd1);
	assign sum_e = big_e - 8'(shamt) + 8'd1;

	// exponent would reach zero or wrap
	assign underflow = ({2'b0, big_e} + 10'd1) <= {4'b0, shamt};

	always_comb begin
		if (a_e == 8'd0 && b_e == 8'd0) q = '0;
		else if (a_e == 8'd0) q = b;
		else if (b_e == 8'd0) q = a;
		else if (underflow || sum == '0) q = '0;
		else q = {a_larger ? a_s : b_s, sum_e, norm[53:36]};
	end
endmodule

/* hw/sample_ingress.sv */
// affine scaler input buffer
`timescale 1ns/10ps

module sample_ingress (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input f27_pkg::in_word_t in_word,
	output logic in_credit,
	input logic room,
	output logic issue_valid,
	output logic signed [15:0] issue_sample,
	output logic [f27_pkg::F27_W-1:0] issue_gain,
	output logic [f27_pkg::F27_W-1:0] issue_offset
);
	f27_pkg::in_word_t mem [f27_pkg::IN_DEPTH];
	logic [$clog2(f27_pkg::IN_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(f27_pkg::IN_DEPTH):0] count;
	f27_pkg::in_word_t head;
	logic head_coef;
	logic pop;
	logic [f27_pkg::F27_W-1:0] gain_q, offset_q;

	// head word, seen through both views of the union
	assign head = mem[rd_ptr];
	assign head_coef = head.coef_view.kind;

	// coefficients always drain, samples wait for space downstream
	assign pop = (count != 0) && (head_coef || room);
	// each pop hands one credit back to the sender
	assign in_credit = pop;

	assign issue_valid = pop && !head_coef;
	assign issue_sample = head.sample_view.sample;
	// a sample uses the values in force in its own issue cycle
	assign issue_gain = gain_q;
	assign issue_offset = offset_q;

	// storage, the sender never writes without a credit
	always_ff @(posedge clk) begin
		if (in_valid) mem[wr_ptr] <= in_word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap naturally, depth is a power of two
			if (in_valid) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// coefficient registers, loaded when their word is popped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gain_q <= f27_pkg::GAIN_RESET;
			offset_q <= f27_pkg::OFFSET_RESET;
		end else if (pop && head_coef) begin
			if (head.coef_view.sel) offset_q <= head.coef_view.coef;
			else gain_q <= head.coef_view.coef;
		end
	end
endmodule

/* hw/affine_pipe.sv */
// three-stage affine float pipeline
`timescale 1ns/10ps

module affine_pipe (
	input logic clk,
	input logic arst_n,
	input logic issue_valid,
	input logic signed [15:0] issue_sample,
	input logic [f27_pkg::F27_W-1:0] issue_gain,
	input logic [f27_pkg::F27_W-1:0] issue_offset,
	output logic res_valid,
	output logic signed [15:0] res_sample
);
	logic [f27_pkg::F27_W-1:0] x_f;
	logic [f27_pkg::F27_W-1:0] prod_f;
	logic [f27_pkg::F27_W-1:0] sum_f;
	logic signed [15:0] sum_i;

	// stage registers, one valid bit per stage
	logic s1_valid, s2_valid, s3_valid;
	logic [f27_pkg::F27_W-1:0] s1_x, s1_gain, s1_offset;
	logic [f27_pkg::F27_W-1:0] s2_prod, s2_offset;
	logic signed [15:0] s3_res;

	// sample to float ahead of stage 1
	f27_int2float cvt_in_i (.a(issue_sample), .q(x_f));
	// gain times x between stages 1 and 2
	f27_mul mul_i (.a(s1_x), .b(s1_gain), .q(prod_f));
	// plus offset, then back to integer, between stages 2 and 3
	f27_add add_i (.a(s2_prod), .b(s2_offset), .q(sum_f));
	f27_float2int cvt_out_i (.a(sum_f), .q(sum_i));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else begin
			s1_valid <= issue_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	// data path, coefficients ride along with their sample
	always_ff @(posedge clk) begin
		s1_x <= x_f;
		s1_gain <= issue_gain;
		s1_offset <= issue_offset;
		s2_prod <= prod_f;
		s2_offset <= s1_offset;
		s3_res <= sum_i;
	end

	// result lands three cycles after issue
	assign res_valid = s3_valid;
	assign res_sample = s3_res;
endmodule

/* hw/sample_egress.sv */
// affine scaler output buffer
`timescale 1ns/10ps

module sample_egress (
	input logic clk,
	input logic arst_n,
	input logic issue_valid,
	input logic res_valid,
	input logic signed [15:0] res_sample,
	output logic room,
	input logic out_credit,
	output logic out_valid,
	output logic signed [15:0] out_sample
);
	logic signed [15:0] mem [f27_pkg::OUT_DEPTH];
	logic [$clog2(f27_pkg::OUT_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(f27_pkg::OUT_DEPTH):0] occ;
	logic [$clog2(f27_pkg::OUT_DEPTH):0] in_flight;
	logic [$clog2(f27_pkg::OUT_DEPTH)+1:0] reserved;
	// receiver may grant ahead of data, so plenty of headroom
	logic [15:0] credits;
	logic send;

	// buffered entries plus results still in the pipeline
	assign reserved = {1'b0, occ} + {1'b0, in_flight};
	assign room = reserved < ($bits(reserved))'(f27_pkg::OUT_DEPTH);

	// one send per cycle needs both data and a credit
	assign send = (occ != 0) && (credits != 0);
	assign out_valid = send;
	assign out_sample = mem[rd_ptr];

	// room guarantees a free slot for every result
	always_ff @(posedge clk) begin
		if (res_valid) mem[wr_ptr] <= res_sample;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
			in_flight <= '0;
			credits <= '0;
		end else begin
			if (res_valid) wr_ptr <= wr_ptr + 1'b1;
			if (send) rd_ptr <= rd_ptr + 1'b1;
			case ({res_valid, send})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
			// up on issue, down when the result arrives
			case ({issue_valid, res_valid})
				2'b10: in_flight <= in_flight + 1'b1;
				2'b01: in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
			// grant and spend in one cycle cancel out
			case ({out_credit, send})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end
endmodule

/* hw/f27_affine_top.sv */
// affine scaler top level
`timescale 1ns/10ps

module f27_affine_top (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input f27_pkg::in_word_t in_word,
	output logic in_credit,
	input logic out_credit,
	output logic out_valid,
	output logic signed [15:0] out_sample
);
	// ingress to pipeline and egress
	logic issue_valid;
	logic signed [15:0] issue_sample;
	logic [f27_pkg::F27_W-1:0] issue_gain;
	logic [f27_pkg::F27_W-1:0] issue_offset;
	// egress back to ingress
	logic room;
	// pipeline to egress
	logic res_valid;
	logic signed [15:0] res_sample;

	// word buffer, coefficient registers and sample issue
	sample_ingress ingress_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_word(in_word),
		.in_credit(in_credit),
		.room(room),
		.issue_valid(issue_valid),
		.issue_sample(issue_sample),
		.issue_gain(issue_gain),
		.issue_offset(issue_offset)
	);

	// gain times x plus offset, fixed three-cycle latency
	affine_pipe pipe_i (
		.clk(clk),
		.arst_n(arst_n),
		.issue_valid(issue_valid),
		.issue_sample(issue_sample),
		.issue_gain(issue_gain),
		.issue_offset(issue_offset),
		.res_valid(res_valid),
		.res_sample(res_sample)
	);

	// result buffer, sends only against receiver credits
	sample_egress egress_i (
		.clk(clk),
		.arst_n(arst_n),
		.issue_valid(issue_valid),
		.res_valid(res_valid),
		.res_sample(res_sample),
		.room(room),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);
endmodule

/* testbench/tb_f27_affine.sv */
// affine scaler testbench
`timescale 1ns/10ps

module tb_f27_affine;
	localparam int MAX_ENTRIES = 256;
	localparam int MAX_TESTS = 256;

	logic clk = 1'b0;
	logic arst_n;
	logic in_valid = 1'b0;
	f27_pkg::in_word_t in_word = '0;
	logic in_credit;
	logic out_credit = 1'b0;
	logic out_valid;
	logic signed [15:0] out_sample;

	// file entries, kind in [43:40], test number in [39:32], payload below
	logic [43:0] entries [MAX_ENTRIES];
	logic [31:0] in_words [$];
	logic signed [15:0] exp_vals [$];
	int exp_tests [$];
	int expected_count [MAX_TESTS];
	int checked [MAX_TESTS];
	int test_fails [MAX_TESTS];
	int n_tests = 0;
	int limit = 0;

	// run state
	int sent = 0;
	int credit_pulses = 0;
	int grants = 0;
	int outputs = 0;
	int n_checked = 0;
	int passes = 0;
	int fails = 0;
	int cycles = 0;
	logic [31:0] lfsr = 32'he0a8_8fa7;

	f27_affine_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_word(in_word),
		.in_credit(in_credit),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// compare one result with the next expected value in stream order
	task automatic check_result(input logic signed [15:0] got);
		int t;
		logic signed [15:0] want;
		assert (n_checked < exp_vals.size())
		else begin
			$display("output %0d at %0t ns came after the last expected result", got, $time);
			fails = fails + 1;
		end
		if (n_checked < exp_vals.size()) begin
			want = exp_vals[n_checked];
			t = exp_tests[n_checked];
			assert (got == want) passes = passes + 1;
			else begin
				$display("Error at %0t ns: test %0d expected %0d observed %0d", $time, t, want, got);
				fails = fails + 1;
				test_fails[t] = test_fails[t] + 1;
			end
			n_checked = n_checked + 1;
			checked[t] = checked[t] + 1;
			// last result of its test
			if (checked[t] == expected_count[t])
				$display("test %0d finished, %0d of %0d results wrong", t, test_fails[t],
					expected_count[t]);
		end
	endtask

	// sender, one word per cycle while fewer than IN_DEPTH are outstanding
	always @(posedge clk) begin
		if (arst_n && sent < in_words.size() && sent - credit_pulses < f27_pkg::IN_DEPTH) begin
			in_valid <= 1'b1;
			in_word <= in_words[sent];
			sent <= sent + 1;
		end else begin
			in_valid <= 1'b0;
		end
	end

	// receiver grants, none at all for 50 of every 150 cycles
	always @(posedge clk) begin
		if (!arst_n || cycles % 150 < 50) begin
			out_credit <= 1'b0;
		end else begin
			out_credit <= lfsr[0];
			lfsr <= lfsr_next(lfsr);
		end
	end

	// monitor for both credit loops and the results
	always @(posedge clk) begin
		if (arst_n) begin
			if (out_credit) grants <= grants + 1;
			if (in_credit) begin
				assert (credit_pulses < sent)
				else begin
					$display("in_credit pulsed at %0t ns with no word outstanding", $time);
					fails = fails + 1;
				end
				credit_pulses <= credit_pulses + 1;
			end
			if (out_valid) begin
				// a send needs a grant seen on an earlier edge
				assert (outputs + 1 <= grants)
				else begin
					$display("out_valid at %0t ns without a granted credit", $time);
					fails = fails + 1;
				end
				outputs <= outputs + 1;
				check_result(out_sample);
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("run timed out after %0d cycles with %0d of %0d results seen", cycles,
				n_checked, exp_vals.size());
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		int kind;
		int t;
		int end_fails;
		arst_n = 1'b0;
		end_fails = 0;
		for (i = 0; i < MAX_ENTRIES; i++) entries[i] = '0;
		$readmemh("testbench/affine_tests.txt", entries);
		// kind 0 marks the end of the data
		i = 0;
		while (i < MAX_ENTRIES && entries[i][43:40] != 4'h0) begin
			kind = int'(entries[i][43:40]);
			t = int'(entries[i][39:32]);
			if (kind == 1) begin
				in_words.push_back(entries[i][31:0]);
			end else begin
				exp_vals.push_back($signed(entries[i][15:0]));
				exp_tests.push_back(t);
				expected_count[t] = expected_count[t] + 1;
				if (t > n_tests) n_tests = t;
			end
			i++;
		end
		limit = 40 * i + 200;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		// every result checked and every word handed back
		while (n_checked < exp_vals.size() || credit_pulses < in_words.size()) @(posedge clk);
		// quiet tail, so a stray extra output is still caught
		repeat (20) @(posedge clk);
		assert (credit_pulses == in_words.size())
		else begin
			$display("in_credit pulsed %0d times for %0d words sent", credit_pulses, sent);
			end_fails = 1;
		end
		$display("%0d tests, %0d checks passed, %0d failed", n_tests, passes, fails + end_fails);
		if (fails + end_fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end
endmodule

/* vlog.f */
hw/f27_pkg.sv
hw/f27_ops.sv
hw/sample_ingress.sv
hw/affine_pipe.sv
hw/sample_egress.sv
hw/f27_affine_top.sv
testbench/tb_f27_affine.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_f27_affine
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timescale 1ns/10ps -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the testbench printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/affine_tests.txt */
// kind(1) test(2) payload(8): kind 1 sends the payload as an input word,
// kind 2 expects the payload's low 16 bits as the next output sample
// test 1 identity with reset coefficients
10100000005 20100000005 1010000FFF9 2010000FFF9
101000003E8 201000003E8 10100008001 20100008001
10100000000 20100000000 10100007FFF 20100007FFF
1010000FFFF 2010000FFFF
// test 2 gain 2.0, offset 10.0, gain 0.5 loaded between samples
10200000003 20200000003 10282000000
10200000003 20200000006 1020000FFCE 2020000FF9C
102C2090000
10200000007 20200000018 1020000FFEC 2020000FFE2
10281F80000
10200000009 2020000000E 1020000FFDF 2020000FFFA
// test 3 clipping with gain 1024, results below one, then -32768 at gain 1.0
103C0000000 10382240000
10300000064 20300007FFF 1030000FFD8 20300008001
10300000000 20300000000 1030000001F 20300007C00
10381F40000 10300000003 20300000000 1030000FFFE 20300000000
103C1FA0000 10300000003 20300000001
10381FC0000 103C0000000 10300008000 20300008001
// test 4 gain -3.0 and offset -100.0 over a longer burst
10486020000 104C6164000
10400000032 2040000FF06 1040000FFCE 20400000032
10400000001 2040000FF99 1040000000C 2040000FF78
1040000FFFF 2040000FF9F 10400000000 2040000FF9C
10400000064 2040000FE70 1040000FF9C 204000000C8
10400000021 2040000FF39
// test 5 gain 1.5 and offset 10.0
10581FE0000 105C2090000
10500000002 2050000000D 10500000004 20500000010
1050000FFFA 20500000001 1050000000A 20500000019
